/* pcie_phy_pkg.sv */
package pcie_phy_pkg;

  // symbol and word geometry
  localparam int SYM_W  = 8;
  localparam int LANES  = 4;
  localparam int DATA_W = SYM_W * LANES;

  // pipe width select, encoded as a bit count
  localparam int PIPE_W = 6;

  // scrambler LFSR
  localparam int LFSR_W = 16;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hFFFF;

  // feedback taps for x^16+x^5+x^4+x^3+1, galois form
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'h0038;

  // K symbol codes
  // comma
  localparam logic [SYM_W-1:0] COM = 8'hBC;
  // skip
  localparam logic [SYM_W-1:0] SKP = 8'h1C;
  // pad
  localparam logic [SYM_W-1:0] PAD_ = 8'hF7;

  // per-lane symbol class from the decode stage
  typedef enum logic [2:0] {
    // scrambled data byte
    SYM_DATA,
    // comma, reseeds the LFSR for the next symbol
    SYM_COM,
    // skip, LFSR holds
    SYM_SKP,
    // any other control symbol, LFSR advances
    SYM_KCTL,
    // lane outside the active width
    SYM_IDLE
  } sym_class_e;

  // legal PIPE widths, value equals the bit count
  typedef enum logic [PIPE_W-1:0] {
    PW_8  = 6'd8,
    PW_16 = 6'd16,
    PW_32 = 6'd32
  } pipe_width_e;

endpackage

/* scramble_if.sv */
`timescale 1ns/1ps

interface scramble_if;

  // word qualifier
  logic valid;

  // raw symbols, byte i on bits [8i+7:8i]
  logic [pcie_phy_pkg::DATA_W-1:0] data;
  logic [pcie_phy_pkg::LANES-1:0]  k;

  // class per byte lane
  pcie_phy_pkg::sym_class_e [pcie_phy_pkg::LANES-1:0] cls;

  // lanes inside the configured width
  logic [pcie_phy_pkg::LANES-1:0] active_mask;

  modport dec (
    output valid,
    output data,
    output k,
    output cls,
    output active_mask
  );

  modport exe (
    input valid,
    input data,
    input k,
    input cls,
    input active_mask
  );

endinterface

/* symbol_decode.sv */
`timescale 1ns/1ps

module symbol_decode (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [pcie_phy_pkg::DATA_W-1:0]   data_in_i,
  input  logic [pcie_phy_pkg::LANES-1:0]    data_k_in_i,
  input  logic                              data_valid_i,
  input  logic [pcie_phy_pkg::PIPE_W-1:0]   pipe_width_i,
  scramble_if.dec                           dec
);

  logic [pcie_phy_pkg::LANES-1:0] active_mask_d;
  pcie_phy_pkg::sym_class_e [pcie_phy_pkg::LANES-1:0] cls_d;

  // active lanes are the low bytes; the highest of them goes out first
  always_comb begin
    case (pcie_phy_pkg::pipe_width_e'(pipe_width_i))
      pcie_phy_pkg::PW_8:  active_mask_d = 4'b0001;
      pcie_phy_pkg::PW_16: active_mask_d = 4'b0011;
      pcie_phy_pkg::PW_32: active_mask_d = 4'b1111;
      // illegal width carries no symbols
      default:             active_mask_d = 4'b0000;
    endcase
  end

  // classify each lane
  always_comb begin
    for (int i = 0; i < pcie_phy_pkg::LANES; i++) begin
      if (!active_mask_d[i]) begin
        cls_d[i] = pcie_phy_pkg::SYM_IDLE;
      end else if (!data_k_in_i[i]) begin
        cls_d[i] = pcie_phy_pkg::SYM_DATA;
      end else begin
        case (data_in_i[i*pcie_phy_pkg::SYM_W +: pcie_phy_pkg::SYM_W])
          pcie_phy_pkg::COM:  cls_d[i] = pcie_phy_pkg::SYM_COM;
          pcie_phy_pkg::SKP:  cls_d[i] = pcie_phy_pkg::SYM_SKP;
          default:            cls_d[i] = pcie_phy_pkg::SYM_KCTL;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= data_valid_i;
    end
  end

  // payload only loads on accepted words
  always_ff @(posedge clk_i) begin
    if (data_valid_i) begin
      dec.data        <= data_in_i;
      dec.k           <= data_k_in_i;
      dec.cls         <= cls_d;
      dec.active_mask <= active_mask_d;
    end
  end

endmodule

/* byte_scramble.sv */
`timescale 1ns/1ps

module byte_scramble (
  input  logic [pcie_phy_pkg::LFSR_W-1:0] lfsr_q_i,
  input  logic                            hold_i,
  output logic [pcie_phy_pkg::SYM_W-1:0]  key_o,
  output logic [pcie_phy_pkg::LFSR_W-1:0] lfsr_d_o
);

  logic [pcie_phy_pkg::LFSR_W-1:0] adv_state;

  // key bit 0 is state bit 15, i.e. the first bit shifted out
  assign key_o = {<<{lfsr_q_i[pcie_phy_pkg::LFSR_W-1 -: pcie_phy_pkg::SYM_W]}};

  // eight galois steps, one per key bit
  always_comb begin
    adv_state = lfsr_q_i;
    for (int n = 0; n < pcie_phy_pkg::SYM_W; n++) begin
      adv_state = {adv_state[pcie_phy_pkg::LFSR_W-2:0], adv_state[pcie_phy_pkg::LFSR_W-1]}
                ^ ({pcie_phy_pkg::LFSR_W{adv_state[pcie_phy_pkg::LFSR_W-1]}}
                   & pcie_phy_pkg::LFSR_TAPS);
    end
  end

  // skip and idle lanes leave the state alone
  assign lfsr_d_o = hold_i ? lfsr_q_i : adv_state;

endmodule

/* gen1_scramble.sv */
`timescale 1ns/1ps

module gen1_scramble (
  input  logic                            clk_i,
  input  logic                            rst_i,
  scramble_if.exe                         exe,
  output logic [pcie_phy_pkg::DATA_W-1:0] data_o,
  output logic [pcie_phy_pkg::LANES-1:0]  k_o,
  output logic [pcie_phy_pkg::LANES-1:0]  active_mask_o,
  output logic                            valid_o
);

  // running scrambler state between words
  logic [pcie_phy_pkg::LFSR_W-1:0] lfsr_q;

  // chain[i+1] feeds lane i; chain[LANES] is the stored state
  logic [pcie_phy_pkg::LFSR_W-1:0] chain [pcie_phy_pkg::LANES+1];
  logic [pcie_phy_pkg::LFSR_W-1:0] adv   [pcie_phy_pkg::LANES];
  logic [pcie_phy_pkg::SYM_W-1:0]  key   [pcie_phy_pkg::LANES];
  logic [pcie_phy_pkg::LANES-1:0]  hold;
  logic [pcie_phy_pkg::DATA_W-1:0] data_d;

  assign chain[pcie_phy_pkg::LANES] = lfsr_q;

  // lanes run from byte 3 down to byte 0, which is time order.
  // unused lanes sit above the active ones and just hold
  for (genvar i = 0; i < pcie_phy_pkg::LANES; i++) begin : g_lane

    assign hold[i] = (exe.cls[i] == pcie_phy_pkg::SYM_SKP)
                  || (exe.cls[i] == pcie_phy_pkg::SYM_IDLE);

    byte_scramble u_byte_scramble (
      .lfsr_q_i (chain[i+1]),
      .hold_i   (hold[i]),
      .key_o    (key[i]),
      .lfsr_d_o (adv[i])
    );

    // comma restarts the sequence for the next symbol
    assign chain[i] = (exe.cls[i] == pcie_phy_pkg::SYM_COM) ? pcie_phy_pkg::LFSR_SEED
                                                           : adv[i];

    // only data bytes get the key, K symbols go through as is
    always_comb begin
      if (exe.cls[i] == pcie_phy_pkg::SYM_DATA) begin
        data_d[i*pcie_phy_pkg::SYM_W +: pcie_phy_pkg::SYM_W] =
          exe.data[i*pcie_phy_pkg::SYM_W +: pcie_phy_pkg::SYM_W] ^ key[i];
      end else begin
        data_d[i*pcie_phy_pkg::SYM_W +: pcie_phy_pkg::SYM_W] =
          exe.data[i*pcie_phy_pkg::SYM_W +: pcie_phy_pkg::SYM_W];
      end
    end

  end

  // state only moves on valid words
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q  <= pcie_phy_pkg::LFSR_SEED;
      valid_o <= 1'b0;
    end else begin
      valid_o <= exe.valid;
      if (exe.valid) begin
        lfsr_q <= chain[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe.valid) begin
      data_o        <= data_d;
      k_o           <= exe.k;
      active_mask_o <= exe.active_mask;
    end
  end

endmodule

/* lane_result.sv */
`timescale 1ns/1ps

module lane_result (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [pcie_phy_pkg::DATA_W-1:0] data_i,
  input  logic [pcie_phy_pkg::LANES-1:0]  k_i,
  input  logic [pcie_phy_pkg::LANES-1:0]  active_mask_i,
  input  logic                            valid_i,
  output logic [pcie_phy_pkg::DATA_W-1:0] data_out_o,
  output logic [pcie_phy_pkg::LANES-1:0]  data_k_out_o,
  output logic                            data_valid_o
);

  logic [pcie_phy_pkg::DATA_W-1:0] byte_mask;

  // widen the lane mask to one bit per data bit
  for (genvar i = 0; i < pcie_phy_pkg::LANES; i++) begin : g_mask
    assign byte_mask[i*pcie_phy_pkg::SYM_W +: pcie_phy_pkg::SYM_W] =
      {pcie_phy_pkg::SYM_W{active_mask_i[i]}};
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_out_o   <= '0;
      data_k_out_o <= '0;
      data_valid_o <= 1'b0;
    end else begin
      data_valid_o <= valid_i;
      if (valid_i) begin
        data_out_o   <= data_i & byte_mask;
        data_k_out_o <= k_i & active_mask_i;
      end else begin
        // output bus reads zero between words
        data_out_o   <= '0;
        data_k_out_o <= '0;
      end
    end
  end

endmodule

/* pcie_gen1_scrambler_top.sv */
`timescale 1ns/1ps

module pcie_gen1_scrambler_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [pcie_phy_pkg::DATA_W-1:0] data_in_i,
  input  logic [pcie_phy_pkg::LANES-1:0]  data_k_in_i,
  input  logic                            data_valid_i,
  input  logic [pcie_phy_pkg::PIPE_W-1:0] pipe_width_i,
  output logic [pcie_phy_pkg::DATA_W-1:0] data_out_o,
  output logic [pcie_phy_pkg::LANES-1:0]  data_k_out_o,
  output logic                            data_valid_o
);

  scramble_if dec_exe ();

  // execute to result
  logic [pcie_phy_pkg::DATA_W-1:0] exe_data;
  logic [pcie_phy_pkg::LANES-1:0]  exe_k;
  logic [pcie_phy_pkg::LANES-1:0]  exe_active_mask;
  logic                            exe_valid;

  symbol_decode u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .data_in_i    (data_in_i),
    .data_k_in_i  (data_k_in_i),
    .data_valid_i (data_valid_i),
    .pipe_width_i (pipe_width_i),
    .dec          (dec_exe.dec)
  );

  gen1_scramble u_scramble (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .exe           (dec_exe.exe),
    .data_o        (exe_data),
    .k_o           (exe_k),
    .active_mask_o (exe_active_mask),
    .valid_o       (exe_valid)
  );

  lane_result u_result (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .data_i        (exe_data),
    .k_i           (exe_k),
    .active_mask_i (exe_active_mask),
    .valid_i       (exe_valid),
    .data_out_o    (data_out_o),
    .data_k_out_o  (data_k_out_o),
    .data_valid_o  (data_valid_o)
  );

endmodule

/* tb_pcie_gen1_scrambler.sv */
`timescale 1ns/1ps

module tb_pcie_gen1_scrambler;

  localparam int TIMEOUT_CYCLES = 20;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] data_in_i;
  logic [3:0]  data_k_in_i;
  logic        data_valid_i;
  logic [5:0]  pipe_width_i;
  logic [31:0] data_out_o;
  logic [3:0]  data_k_out_o;
  logic        data_valid_o;

  // words in flight, slot 2 is due at the current falling edge
  logic        exp_valid [3];
  logic [31:0] exp_data  [3];
  logic [3:0]  exp_k     [3];

  logic [15:0] model_lfsr;
  logic        seen_valid;
  int          checks;
  int          errors;
  int          timeouts;

  pcie_gen1_scrambler_top uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .data_in_i    (data_in_i),
    .data_k_in_i  (data_k_in_i),
    .data_valid_i (data_valid_i),
    .pipe_width_i (pipe_width_i),
    .data_out_o   (data_out_o),
    .data_k_out_o (data_k_out_o),
    .data_valid_o (data_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // x^16+x^5+x^4+x^3+1, msb shifted out feeds taps 5,4,3 and 0
  function automatic logic [15:0] advance8(input logic [15:0] s);
    logic [15:0] r;
    r = s;
    for (int n = 0; n < 8; n++) begin
      if (r[15]) begin
        r = (r << 1) ^ 16'h0039;
      end else begin
        r = r << 1;
      end
    end
    return r;
  endfunction

  function automatic logic [7:0] key_of(input logic [15:0] s);
    logic [7:0] key;
    for (int b = 0; b < 8; b++) begin
      key[b] = s[15 - b];
    end
    return key;
  endfunction

  // highest active byte goes first in time
  task automatic model_word(input logic [31:0] din, input logic [3:0] kin, input int width,
                            output logic [31:0] dout, output logic [3:0] kout);
    logic [7:0] sym;
    dout = '0;
    kout = '0;
    for (int lane = width / 8 - 1; lane >= 0; lane--) begin
      sym = din[lane*8 +: 8];
      if (kin[lane]) begin
        dout[lane*8 +: 8] = sym;
        kout[lane] = 1'b1;
        if (sym == pcie_phy_pkg::COM) begin
          model_lfsr = pcie_phy_pkg::LFSR_SEED;
        end else if (sym != pcie_phy_pkg::SKP) begin
          model_lfsr = advance8(model_lfsr);
        end
      end else begin
        dout[lane*8 +: 8] = sym ^ key_of(model_lfsr);
        model_lfsr = advance8(model_lfsr);
      end
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // one clock: check the due word, then drive the next input
  task automatic tick(input logic valid, input logic [31:0] din, input logic [3:0] kin,
                      input int width);
    logic [31:0] dexp;
    logic [3:0]  kexp;
    @(negedge clk_i);
    seen_valid = data_valid_o;
    check_val("data_valid_o", {31'd0, data_valid_o}, {31'd0, exp_valid[2]});
    if (exp_valid[2]) begin
      check_val("data_out_o", data_out_o, exp_data[2]);
      check_val("data_k_out_o", {28'd0, data_k_out_o}, {28'd0, exp_k[2]});
    end else begin
      check_val("data_out_o", data_out_o, 32'd0);
      check_val("data_k_out_o", {28'd0, data_k_out_o}, 32'd0);
    end
    for (int s = 2; s > 0; s--) begin
      exp_valid[s] = exp_valid[s-1];
      exp_data[s]  = exp_data[s-1];
      exp_k[s]     = exp_k[s-1];
    end
    dexp = '0;
    kexp = '0;
    if (valid) begin
      model_word(din, kin, width, dexp, kexp);
    end
    exp_valid[0] = valid;
    exp_data[0]  = dexp;
    exp_k[0]     = kexp;
    data_valid_i = valid;
    data_in_i    = din;
    data_k_in_i  = kin;
    pipe_width_i = width[5:0];
  endtask

  task automatic wait_for_valid(output int cycles);
    cycles = 0;
    seen_valid = 1'b0;
    while (!seen_valid) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("timeout: data_valid_o never went high");
        timeouts++;
        break;
      end
      tick(1'b0, 32'd0, 4'd0, 32);
      cycles++;
    end
  endtask

  task automatic drain();
    int cnt;
    cnt = 0;
    while (exp_valid[0] || exp_valid[1] || exp_valid[2]) begin
      if (cnt == TIMEOUT_CYCLES) begin
        $display("timeout: words still in flight after drain");
        timeouts++;
        break;
      end
      tick(1'b0, 32'd0, 4'd0, 32);
      cnt++;
    end
  endtask

  task automatic reset_and_first_word();
    logic [31:0] din;
    int lat;
    repeat (5) tick(1'b0, 32'd0, 4'd0, 32);
    din = $urandom;
    tick(1'b1, din, 4'd0, 32);
    wait_for_valid(lat);
    check_val("latency", lat, 32'd3);
    // seed key is all ones
    check_val("data_out_o[31:24]", {24'd0, data_out_o[31:24]}, {24'd0, din[31:24] ^ 8'hFF});
    drain();
  endtask

  task automatic random_data_words();
    int gap;
    for (int w = 0; w < 40; w++) begin
      tick(1'b1, $urandom, 4'd0, 32);
      gap = $urandom % 3;
      repeat (gap) tick(1'b0, 32'd0, 4'd0, 32);
    end
    drain();
  endtask

  task automatic com_reseed();
    logic [31:0] din;
    int lat;
    din = $urandom;
    din[23:16] = pcie_phy_pkg::COM;
    tick(1'b1, din, 4'b0100, 32);
    wait_for_valid(lat);
    check_val("data_out_o[23:16]", {24'd0, data_out_o[23:16]}, {24'd0, pcie_phy_pkg::COM});
    check_val("data_out_o[15:8]", {24'd0, data_out_o[15:8]}, {24'd0, din[15:8] ^ 8'hFF});
    // comma at the end of a word reseeds the next word
    din = $urandom;
    din[7:0] = pcie_phy_pkg::COM;
    tick(1'b1, din, 4'b0001, 32);
    wait_for_valid(lat);
    din = $urandom;
    tick(1'b1, din, 4'b0000, 32);
    wait_for_valid(lat);
    check_val("data_out_o[31:24]", {24'd0, data_out_o[31:24]}, {24'd0, din[31:24] ^ 8'hFF});
    drain();
  endtask

  task automatic skip_and_k_symbols();
    logic [31:0] din;
    int lat;
    din = {pcie_phy_pkg::SKP, 8'($urandom), pcie_phy_pkg::PAD_, 8'($urandom)};
    tick(1'b1, din, 4'b1010, 32);
    din = {8'($urandom), pcie_phy_pkg::SKP, pcie_phy_pkg::SKP, 8'($urandom)};
    tick(1'b1, din, 4'b0110, 32);
    tick(1'b1, $urandom, 4'b0000, 32);
    drain();
    // skips between comma and data leave the seed key in place
    din = {pcie_phy_pkg::COM, pcie_phy_pkg::SKP, 8'($urandom), pcie_phy_pkg::SKP};
    tick(1'b1, din, 4'b1101, 32);
    wait_for_valid(lat);
    check_val("data_out_o[15:8]", {24'd0, data_out_o[15:8]}, {24'd0, din[15:8] ^ 8'hFF});
    drain();
  endtask

  task automatic narrow_widths();
    for (int w = 0; w < 6; w++) begin
      tick(1'b1, $urandom, 4'b1100, 16);
    end
    for (int w = 0; w < 6; w++) begin
      tick(1'b1, $urandom, 4'b1110, 8);
      tick(1'b0, 32'd0, 4'd0, 8);
    end
    tick(1'b1, $urandom, 4'b0000, 32);
    drain();
  endtask

  initial begin
    void'($urandom(32'h105017a2));
    rst_i        = 1'b1;
    data_in_i    = '0;
    data_k_in_i  = '0;
    data_valid_i = 1'b0;
    pipe_width_i = 6'd32;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    seen_valid   = 1'b0;
    model_lfsr   = pcie_phy_pkg::LFSR_SEED;
    for (int s = 0; s < 3; s++) begin
      exp_valid[s] = 1'b0;
      exp_data[s]  = '0;
      exp_k[s]     = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;

    reset_and_first_word();
    random_data_words();
    com_reseed();
    skip_and_k_symbols();
    narrow_widths();

    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* pcie_gen1_scrambler.f */
pcie_phy_pkg.sv
scramble_if.sv
symbol_decode.sv
byte_scramble.sv
gen1_scramble.sv
lane_result.sv
pcie_gen1_scrambler_top.sv
tb_pcie_gen1_scrambler.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module tb_pcie_gen1_scrambler \
  -f pcie_gen1_scrambler.f \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
